// File: common/rv_pkg.sv
package rv_pkg;

  // Datapath and register file sizes
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;

  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;
  localparam logic [XLEN-1:0] PC_STEP  = 32'd4;  // One word per instruction

  // RV32I major opcodes, bits [6:0] of the instruction
  typedef enum logic [6:0] {
    OP_LOAD     = 7'b000_0011,  // Not executed, decoded as illegal
    OP_MISC_MEM = 7'b000_1111,
    OP_REG_IMM  = 7'b001_0011,
    OP_AUIPC    = 7'b001_0111,
    OP_STORE    = 7'b010_0011,  // Not executed, decoded as illegal
    OP_REG_REG  = 7'b011_0011,
    OP_LUI      = 7'b011_0111,
    OP_BRANCH   = 7'b110_0011,
    OP_JALR     = 7'b110_0111,
    OP_JAL      = 7'b110_1111,
    OP_SYSTEM   = 7'b111_0011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  // Instruction class seen by execute
  typedef enum logic [2:0] {
    KIND_NOP,
    KIND_ALU,
    KIND_LUI,
    KIND_AUIPC,
    KIND_BRANCH,
    KIND_JAL,
    KIND_JALR,
    KIND_HALT
  } insn_kind_e;

  // Branch conditions use the funct3 encoding directly
  typedef enum logic [2:0] {
    BR_EQ  = 3'b000,
    BR_NE  = 3'b001,
    BR_LT  = 3'b100,
    BR_GE  = 3'b101,
    BR_LTU = 3'b110,
    BR_GEU = 3'b111
  } branch_op_e;

endpackage

// File: common/rv_exec_if.sv
`timescale 1ns/10ps

// Decoded instruction with its operands, next PC comes back from execute
interface rv_exec_if;

  rv_pkg::insn_kind_e          kind;
  rv_pkg::alu_op_e             alu_op;
  rv_pkg::branch_op_e          branch_op;
  logic                        use_imm;  // ALU second operand is imm
  logic [rv_pkg::REG_ADDR_W-1:0] rd;
  logic [rv_pkg::XLEN-1:0]     imm;
  logic [rv_pkg::XLEN-1:0]     cur_pc;
  logic [rv_pkg::XLEN-1:0]     rs1_data;
  logic [rv_pkg::XLEN-1:0]     rs2_data;
  logic [rv_pkg::XLEN-1:0]     next_pc;

  modport dec (
    output kind, alu_op, branch_op, use_imm, rd, imm, cur_pc, rs1_data, rs2_data,
    input  next_pc
  );

  modport exe (
    input  kind, alu_op, branch_op, use_imm, rd, imm, cur_pc, rs1_data, rs2_data,
    output next_pc
  );

endinterface

// File: common/rv_rf_read_if.sv
`timescale 1ns/10ps

// Two combinational read ports of the register file
interface rv_rf_read_if;

  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr;
  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr;
  logic [rv_pkg::XLEN-1:0]       rs1_data;
  logic [rv_pkg::XLEN-1:0]       rs2_data;

  modport reader (
    output rs1_addr, rs2_addr,
    input  rs1_data, rs2_data
  );

  modport file (
    input  rs1_addr, rs2_addr,
    output rs1_data, rs2_data
  );

endinterface

// File: src/rv_fetch_decode.sv
`timescale 1ns/10ps

module rv_fetch_decode (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [rv_pkg::XLEN-1:0]    insn,
  output logic [rv_pkg::XLEN-1:0]    pc,
  rv_rf_read_if.reader               rf,
  rv_exec_if.dec                     ex
);

  rv_pkg::opcode_e                 opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [rv_pkg::REG_ADDR_W-1:0]   rs1;
  logic [rv_pkg::REG_ADDR_W-1:0]   rs2;
  logic [rv_pkg::REG_ADDR_W-1:0]   rd;
  logic [rv_pkg::XLEN-1:0]         imm_i;
  logic [rv_pkg::XLEN-1:0]         imm_b;
  logic [rv_pkg::XLEN-1:0]         imm_j;
  logic [rv_pkg::XLEN-1:0]         imm_u;
  logic                            f7_base;
  logic                            f7_alt;
  rv_pkg::alu_op_e                 f3_alu_op;
  rv_pkg::insn_kind_e              kind;
  logic                            use_imm;
  logic [rv_pkg::XLEN-1:0]         imm;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_pkg::RESET_PC;
    end else begin
      pc <= ex.next_pc;
    end
  end

  // Field split
  assign opcode = rv_pkg::opcode_e'(insn[6:0]);
  assign rd     = insn[11:7];
  assign funct3 = insn[14:12];
  assign rs1    = insn[19:15];
  assign rs2    = insn[24:20];
  assign funct7 = insn[31:25];

  assign f7_base = (funct7 == 7'b000_0000);
  assign f7_alt  = (funct7 == 7'b010_0000);  // SUB and SRA/SRAI

  // Sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
  assign imm_u = {insn[31:12], 12'h000};

  // funct3 to ALU op, shared by both ALU groups
  always_comb begin
    case (funct3)
      3'b000:  f3_alu_op = (f7_alt && opcode == rv_pkg::OP_REG_REG) ? rv_pkg::ALU_SUB
                                                                     : rv_pkg::ALU_ADD;
      3'b001:  f3_alu_op = rv_pkg::ALU_SLL;
      3'b010:  f3_alu_op = rv_pkg::ALU_SLT;
      3'b011:  f3_alu_op = rv_pkg::ALU_SLTU;
      3'b100:  f3_alu_op = rv_pkg::ALU_XOR;
      3'b101:  f3_alu_op = f7_alt ? rv_pkg::ALU_SRA : rv_pkg::ALU_SRL;
      3'b110:  f3_alu_op = rv_pkg::ALU_OR;
      default: f3_alu_op = rv_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    kind    = rv_pkg::KIND_NOP;
    use_imm = 1'b0;
    imm     = imm_i;
    case (opcode)
      rv_pkg::OP_LUI: begin
        kind = rv_pkg::KIND_LUI;
        imm  = imm_u;
      end
      rv_pkg::OP_AUIPC: begin
        kind = rv_pkg::KIND_AUIPC;
        imm  = imm_u;
      end
      rv_pkg::OP_JAL: begin
        kind = rv_pkg::KIND_JAL;
        imm  = imm_j;
      end
      rv_pkg::OP_JALR: begin
        if (funct3 == 3'b000) kind = rv_pkg::KIND_JALR;
      end
      rv_pkg::OP_BRANCH: begin
        imm = imm_b;
        if (funct3[2:1] != 2'b01) kind = rv_pkg::KIND_BRANCH;  // 010 and 011 undefined
      end
      rv_pkg::OP_REG_IMM: begin
        use_imm = 1'b1;
        if (funct3 == 3'b001) begin
          if (f7_base) kind = rv_pkg::KIND_ALU;
        end else if (funct3 == 3'b101) begin
          if (f7_base || f7_alt) kind = rv_pkg::KIND_ALU;
        end else begin
          kind = rv_pkg::KIND_ALU;
        end
      end
      rv_pkg::OP_REG_REG: begin
        if (f7_base || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101))) begin
          kind = rv_pkg::KIND_ALU;
        end
      end
      rv_pkg::OP_SYSTEM: begin
        if (insn[31:7] == '0) kind = rv_pkg::KIND_HALT;  // ECALL only
      end
      rv_pkg::OP_MISC_MEM: kind = rv_pkg::KIND_NOP;  // FENCE
      rv_pkg::OP_LOAD, rv_pkg::OP_STORE: kind = rv_pkg::KIND_NOP;  // No data memory
      default: kind = rv_pkg::KIND_NOP;
    endcase

    // Results bound for x0 are dropped, jumps still redirect
    if (rd == '0 && (kind == rv_pkg::KIND_ALU || kind == rv_pkg::KIND_LUI ||
                     kind == rv_pkg::KIND_AUIPC)) begin
      kind = rv_pkg::KIND_NOP;
    end
  end

  assign rf.rs1_addr = rs1;
  assign rf.rs2_addr = rs2;

  assign ex.kind      = kind;
  assign ex.alu_op    = f3_alu_op;
  assign ex.branch_op = rv_pkg::branch_op_e'(funct3);
  assign ex.use_imm   = use_imm;
  assign ex.rd        = rd;
  assign ex.imm       = imm;
  assign ex.cur_pc    = pc;
  assign ex.rs1_data  = rf.rs1_data;
  assign ex.rs2_data  = rf.rs2_data;

endmodule

// File: src/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst,
  rv_rf_read_if.file                    rd_port,
  input  logic                          we,
  input  logic [rv_pkg::REG_ADDR_W-1:0] waddr,
  input  logic [rv_pkg::XLEN-1:0]       wdata
);

  // x0 has no storage
  logic [rv_pkg::XLEN-1:0] regs [1:rv_pkg::NUM_REGS-1];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < rv_pkg::NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Combinational reads
  assign rd_port.rs1_data = (rd_port.rs1_addr == '0) ? '0 : regs[rd_port.rs1_addr];
  assign rd_port.rs2_data = (rd_port.rs2_addr == '0) ? '0 : regs[rd_port.rs2_addr];

endmodule

// File: src/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  rv_exec_if.exe                        ex,
  output logic                          halt,
  output logic                          wb_valid,
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [rv_pkg::XLEN-1:0]       wb_data
);

  logic [rv_pkg::XLEN-1:0] op_b;
  logic [4:0]              shamt;
  logic [rv_pkg::XLEN-1:0] alu_result;
  logic [rv_pkg::XLEN-1:0] link_pc;
  logic [rv_pkg::XLEN-1:0] pc_target;
  logic [rv_pkg::XLEN-1:0] jalr_target;
  logic                    taken;

  assign op_b  = ex.use_imm ? ex.imm : ex.rs2_data;
  assign shamt = op_b[4:0];

  always_comb begin
    case (ex.alu_op)
      rv_pkg::ALU_ADD:  alu_result = ex.rs1_data + op_b;
      rv_pkg::ALU_SUB:  alu_result = ex.rs1_data - op_b;
      rv_pkg::ALU_SLL:  alu_result = ex.rs1_data << shamt;
      rv_pkg::ALU_SLT:  alu_result = {{(rv_pkg::XLEN-1){1'b0}},
                                      $signed(ex.rs1_data) < $signed(op_b)};
      rv_pkg::ALU_SLTU: alu_result = {{(rv_pkg::XLEN-1){1'b0}}, ex.rs1_data < op_b};
      rv_pkg::ALU_XOR:  alu_result = ex.rs1_data ^ op_b;
      rv_pkg::ALU_SRL:  alu_result = ex.rs1_data >> shamt;
      rv_pkg::ALU_SRA:  alu_result = $signed(ex.rs1_data) >>> shamt;
      rv_pkg::ALU_OR:   alu_result = ex.rs1_data | op_b;
      default:          alu_result = ex.rs1_data & op_b;
    endcase
  end

  // Branch compare always on the two registers
  always_comb begin
    case (ex.branch_op)
      rv_pkg::BR_EQ:  taken = (ex.rs1_data == ex.rs2_data);
      rv_pkg::BR_NE:  taken = (ex.rs1_data != ex.rs2_data);
      rv_pkg::BR_LT:  taken = ($signed(ex.rs1_data) < $signed(ex.rs2_data));
      rv_pkg::BR_GE:  taken = ($signed(ex.rs1_data) >= $signed(ex.rs2_data));
      rv_pkg::BR_LTU: taken = (ex.rs1_data < ex.rs2_data);
      default:        taken = (ex.rs1_data >= ex.rs2_data);
    endcase
  end

  assign link_pc     = ex.cur_pc + rv_pkg::PC_STEP;
  assign pc_target   = ex.cur_pc + ex.imm;  // Branch, JAL and AUIPC
  assign jalr_target = ex.rs1_data + ex.imm;

  always_comb begin
    case (ex.kind)
      rv_pkg::KIND_BRANCH: ex.next_pc = taken ? pc_target : link_pc;
      rv_pkg::KIND_JAL:    ex.next_pc = pc_target;
      rv_pkg::KIND_JALR:   ex.next_pc = {jalr_target[rv_pkg::XLEN-1:1], 1'b0};
      default:             ex.next_pc = link_pc;  // ECALL steps too
    endcase
  end

  always_comb begin
    case (ex.kind)
      rv_pkg::KIND_LUI:   wb_data = ex.imm;
      rv_pkg::KIND_AUIPC: wb_data = pc_target;
      rv_pkg::KIND_JAL,
      rv_pkg::KIND_JALR:  wb_data = link_pc;
      default:            wb_data = alu_result;
    endcase
  end

  // Decode already dropped x0 for the ALU and upper-immediate kinds
  always_comb begin
    case (ex.kind)
      rv_pkg::KIND_ALU,
      rv_pkg::KIND_LUI,
      rv_pkg::KIND_AUIPC: wb_valid = 1'b1;
      rv_pkg::KIND_JAL,
      rv_pkg::KIND_JALR:  wb_valid = (ex.rd != '0);
      default:            wb_valid = 1'b0;
    endcase
  end

  assign wb_rd = ex.rd;
  assign halt  = (ex.kind == rv_pkg::KIND_HALT);

endmodule

// File: src/rv_core.sv
`timescale 1ns/10ps

module rv_core (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [rv_pkg::XLEN-1:0]       insn,
  output logic [rv_pkg::XLEN-1:0]       pc,
  output logic                          halt,
  output logic                          wb_valid,  // Commit trace of the register write
  output logic [rv_pkg::REG_ADDR_W-1:0] wb_rd,
  output logic [rv_pkg::XLEN-1:0]       wb_data
);

  rv_rf_read_if rf_rd ();
  rv_exec_if    ex_bus ();

  rv_fetch_decode u_fetch_decode (
    .clk  (clk),
    .rst  (rst),
    .insn (insn),
    .pc   (pc),
    .rf   (rf_rd.reader),
    .ex   (ex_bus.dec)
  );

  rv_regfile u_regfile (
    .clk     (clk),
    .rst     (rst),
    .rd_port (rf_rd.file),
    .we      (wb_valid),
    .waddr   (wb_rd),
    .wdata   (wb_data)
  );

  // Writeback feeds the register file and the top-level trace alike
  rv_execute u_execute (
    .ex       (ex_bus.exe),
    .halt     (halt),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

endmodule

// File: bench/rv_iss.svh
// Program image and reference model state
logic [rv_pkg::XLEN-1:0] prog [0:255];
int                      prog_len;
logic [rv_pkg::XLEN-1:0] model_regs [0:rv_pkg::NUM_REGS-1];
logic [rv_pkg::XLEN-1:0] model_pc;
logic [31:0]             rng_state = 32'd5;

function automatic logic [31:0] xorshift();
  logic [31:0] x;
  x = rng_state;
  x ^= x << 13;
  x ^= x >> 17;
  x ^= x << 5;
  rng_state = x;
  return x;
endfunction

function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, rv_pkg::OP_REG_REG};
endfunction

function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                       input logic [6:0] op);
  return {imm, rd, op};
endfunction

function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_pkg::OP_BRANCH};
endfunction

function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_pkg::OP_JAL};
endfunction

function automatic void emit(input logic [31:0] word);
  prog[prog_len] = word;
  prog_len++;
endfunction

// ADDI x23, x23, 1 sits in every skipped slot
function automatic void emit_marker();
  emit(i_type(12'd1, 5'd23, 3'b000, 5'd23, rv_pkg::OP_REG_IMM));
endfunction

// Taken case first, then the not-taken one, both aimed over a marker
function automatic void branch_pair(input logic [2:0] f3, input logic [4:0] t1, t2, n1, n2);
  emit(b_type(13'd8, t2, t1, f3));
  emit_marker();
  emit(b_type(13'd8, n2, n1, f3));
  emit_marker();
endfunction

function automatic void build_program();
  logic [31:0] r;
  logic [31:0] r2;
  logic [2:0]  f3;
  prog_len = 0;
  emit(u_type(20'h80f0f, 5'd1, rv_pkg::OP_LUI));  // x1 stays negative
  emit(i_type(12'hedd, 5'd1, 3'b000, 5'd1, rv_pkg::OP_REG_IMM));
  for (int i = 2; i < 16; i++) begin
    r = xorshift();
    r2 = xorshift();
    emit(u_type(r[31:12], i[4:0], rv_pkg::OP_LUI));
    emit(i_type(r2[31:20], i[4:0], 3'b000, i[4:0], rv_pkg::OP_REG_IMM));
  end
  emit(i_type(12'h407, 5'd1, 3'b101, 5'd2, rv_pkg::OP_REG_IMM));  // SRAI of negative
  emit(r_type(7'h20, 5'd4, 5'd1, 3'b101, 5'd3));
  emit(r_type(7'h00, 5'd6, 5'd1, 3'b010, 5'd5));
  emit(r_type(7'h00, 5'd6, 5'd1, 3'b011, 5'd6));
  emit(i_type(12'hfff, 5'd1, 3'b011, 5'd7, rv_pkg::OP_REG_IMM));  // SLTIU against -1
  emit(i_type(12'h000, 5'd1, 3'b010, 5'd8, rv_pkg::OP_REG_IMM));
  r = xorshift();
  emit(u_type(r[31:12], 5'd9, rv_pkg::OP_AUIPC));
  for (int n = 0; n < 60; n++) begin
    r = xorshift();
    r2 = xorshift();
    f3 = r[2:0];
    if (r[8]) begin
      emit(r_type((r[9] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'h20 : 7'h00,
                  {1'b0, r[13:10]}, {1'b0, r[17:14]}, f3, {1'b0, r[21:18]}));
    end else if (f3 == 3'b001 || f3 == 3'b101) begin
      emit(i_type({1'b0, r[9] && (f3 == 3'b101), 5'b0_0000, r[7:3]}, {1'b0, r[17:14]},
                  f3, {1'b0, r[21:18]}, rv_pkg::OP_REG_IMM));
    end else begin
      emit(i_type(r2[31:20], {1'b0, r[17:14]}, f3, {1'b0, r[21:18]}, rv_pkg::OP_REG_IMM));
    end
  end
  // Branch operands: x20 = -5, x21 = x22 = 7
  emit(i_type(12'hffb, 5'd0, 3'b000, 5'd20, rv_pkg::OP_REG_IMM));
  emit(i_type(12'd7, 5'd0, 3'b000, 5'd21, rv_pkg::OP_REG_IMM));
  emit(i_type(12'd7, 5'd0, 3'b000, 5'd22, rv_pkg::OP_REG_IMM));
  branch_pair(3'b000, 5'd21, 5'd22, 5'd20, 5'd21);
  branch_pair(3'b001, 5'd20, 5'd21, 5'd21, 5'd22);
  branch_pair(3'b100, 5'd20, 5'd21, 5'd21, 5'd20);
  branch_pair(3'b101, 5'd21, 5'd20, 5'd20, 5'd21);
  branch_pair(3'b110, 5'd21, 5'd20, 5'd20, 5'd21);
  branch_pair(3'b111, 5'd20, 5'd21, 5'd21, 5'd20);
  emit(j_type(21'd8, 5'd24));
  emit_marker();
  emit(j_type(21'd8, 5'd0));  // Link to x0 is dropped
  emit_marker();
  emit(u_type(20'h00000, 5'd25, rv_pkg::OP_AUIPC));
  emit(i_type(12'd13, 5'd25, 3'b000, 5'd26, rv_pkg::OP_JALR));  // Odd target, bit 0 cleared
  emit_marker();
  emit(i_type(12'd25, 5'd25, 3'b000, 5'd0, rv_pkg::OP_JALR));
  emit_marker();
  emit_marker();
  emit(i_type(12'd55, 5'd26, 3'b000, 5'd0, rv_pkg::OP_REG_IMM));
  emit(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd28));  // x0 still reads zero
  emit(r_type(7'h00, 5'd24, 5'd0, 3'b000, 5'd27));
  emit(i_type(12'd0, 5'd1, 3'b010, 5'd29, rv_pkg::OP_LOAD));
  emit(i_type(12'h0ff, 5'd0, 3'b000, 5'd0, rv_pkg::OP_MISC_MEM));
  emit(i_type(12'd0, 5'd0, 3'b000, 5'd0, rv_pkg::OP_SYSTEM));  // ECALL
endfunction

function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                        input logic [31:0] x, input logic [31:0] y);
  logic signed [31:0] sx;
  logic signed [31:0] sy;
  sx = x;
  sy = y;
  case (f3)
    3'b000:  return alt ? x - y : x + y;
    3'b001:  return x << y[4:0];
    3'b010:  return {31'b0, sx < sy};
    3'b011:  return {31'b0, x < y};
    3'b100:  return x ^ y;
    3'b101:  begin
      if (alt) begin
        return sx >>> y[4:0];
      end
      return x >> y[4:0];
    end
    3'b110:  return x | y;
    default: return x & y;
  endcase
endfunction

// One instruction on the model, register file updated here
function automatic void iss_step(input  logic [31:0] word, output logic valid,
                                 output logic [4:0] rd, output logic [31:0] data,
                                 output logic [31:0] next_pc, output logic halt);
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic        take;
  rd    = word[11:7];
  f3    = word[14:12];
  f7    = word[31:25];
  a     = model_regs[word[19:15]];  // Entry 0 is never written
  b     = model_regs[word[24:20]];
  imm_i = {{20{word[31]}}, word[31:20]};
  valid   = 1'b0;
  data    = '0;
  halt    = 1'b0;
  take    = 1'b0;
  next_pc = model_pc + rv_pkg::PC_STEP;
  case (word[6:0])
    rv_pkg::OP_LUI: begin
      valid = 1'b1;
      data  = {word[31:12], 12'h000};
    end
    rv_pkg::OP_AUIPC: begin
      valid = 1'b1;
      data  = model_pc + {word[31:12], 12'h000};
    end
    rv_pkg::OP_JAL: begin
      valid   = 1'b1;
      data    = model_pc + rv_pkg::PC_STEP;
      next_pc = model_pc + {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    end
    rv_pkg::OP_JALR: begin
      if (f3 == 3'b000) begin
        valid   = 1'b1;
        data    = model_pc + rv_pkg::PC_STEP;
        next_pc = (a + imm_i) & ~32'd1;
      end
    end
    rv_pkg::OP_BRANCH: begin
      case (f3)
        3'b000:  take = (a == b);
        3'b001:  take = (a != b);
        3'b100:  take = ($signed(a) < $signed(b));
        3'b101:  take = ($signed(a) >= $signed(b));
        3'b110:  take = (a < b);
        3'b111:  take = (a >= b);
        default: take = 1'b0;
      endcase
      if (take) begin
        next_pc = model_pc + {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
      end
    end
    rv_pkg::OP_REG_IMM: begin
      if (f3 == 3'b001) begin
        valid = (f7 == 7'h00);
      end else if (f3 == 3'b101) begin
        valid = (f7 == 7'h00 || f7 == 7'h20);
      end else begin
        valid = 1'b1;
      end
      data = alu_ref(f3, f3 == 3'b101 && f7 == 7'h20, a, imm_i);
    end
    rv_pkg::OP_REG_REG: begin
      valid = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
      data  = alu_ref(f3, f7 == 7'h20, a, b);
    end
    rv_pkg::OP_SYSTEM: halt = (word[31:7] == '0);
    default: valid = 1'b0;  // Loads, stores, FENCE and unknown opcodes
  endcase
  valid = valid && (rd != 5'd0);
  if (valid) begin
    model_regs[rd] = data;
  end
endfunction

// File: bench/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;

  localparam int          CLK_PERIOD = 8;
  localparam logic [31:0] NOP_WORD   = 32'h0000_0013;  // ADDI x0, x0, 0

  logic                          clk = 1'b0;
  logic                          rst;
  logic [rv_pkg::XLEN-1:0]       insn;
  logic [rv_pkg::XLEN-1:0]       pc;
  logic                          halt;
  logic                          wb_valid;
  logic [rv_pkg::REG_ADDR_W-1:0] wb_rd;
  logic [rv_pkg::XLEN-1:0]       wb_data;

  int   error_count = 0;
  int   retired     = 0;
  logic halt_seen   = 1'b0;

  `include "rv_iss.svh"

  rv_core u_rv_core (
    .clk      (clk),
    .rst      (rst),
    .insn     (insn),
    .pc       (pc),
    .halt     (halt),
    .wb_valid (wb_valid),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  always begin
    #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Addresses past the program read as NOP
  function automatic logic [31:0] fetch_word(input logic [31:0] addr);
    if (addr[1:0] != 2'b00 || addr >= 32'(prog_len * 4)) begin
      return NOP_WORD;
    end
    return prog[addr[9:2]];
  endfunction

  task automatic finish_run();
    $display("run complete: %0d instructions retired, %0d errors", retired, error_count);
    if (error_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  endtask

  initial begin
    rst  = 1'b1;
    insn = NOP_WORD;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    model_pc = rv_pkg::RESET_PC;
    build_program();
    repeat (2) @(posedge clk);
    rst  <= 1'b0;
    insn <= fetch_word(model_pc);
    wait (halt_seen);
    @(negedge clk);  // One cycle past the ECALL
    finish_run();
  end

  // Next word follows the model PC updated on the falling edge
  always @(posedge clk) begin
    if (!rst) begin
      insn <= fetch_word(model_pc);
    end
  end

  always @(negedge clk) begin : compare
    logic [31:0] exp_pc;
    logic        exp_valid;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic [31:0] exp_next;
    logic        exp_halt;
    if (rst) begin
      if (pc !== rv_pkg::RESET_PC) begin
        $display("mismatch pc: expected %h actual %h in reset", rv_pkg::RESET_PC, pc);
        error_count++;
      end
      if (wb_valid !== 1'b0) begin
        $display("mismatch wb_valid: expected %h actual %h in reset", 1'b0, wb_valid);
        error_count++;
      end
      if (halt !== 1'b0) begin
        $display("mismatch halt: expected %h actual %h in reset", 1'b0, halt);
        error_count++;
      end
    end else if (!halt_seen) begin
      exp_pc = model_pc;
      iss_step(insn, exp_valid, exp_rd, exp_data, exp_next, exp_halt);
      if (pc !== exp_pc) begin
        $display("mismatch pc: expected %h actual %h", exp_pc, pc);
        error_count++;
      end
      if (wb_valid !== exp_valid) begin
        $display("mismatch wb_valid: expected %h actual %h at pc %h", exp_valid, wb_valid,
                 exp_pc);
        error_count++;
      end
      if (exp_valid && wb_rd !== exp_rd) begin
        $display("mismatch wb_rd: expected %h actual %h at pc %h", exp_rd, wb_rd, exp_pc);
        error_count++;
      end
      if (exp_valid && wb_data !== exp_data) begin
        $display("mismatch wb_data: expected %h actual %h at pc %h", exp_data, wb_data,
                 exp_pc);
        error_count++;
      end
      if (halt !== exp_halt) begin
        $display("mismatch halt: expected %h actual %h at pc %h", exp_halt, halt, exp_pc);
        error_count++;
      end
      model_pc  = exp_next;
      retired++;
      halt_seen = exp_halt;
    end
  end

  // Three cycles per program word is far beyond the longest path
  initial begin
    int limit_ns;
    wait (prog_len > 0);
    limit_ns = (prog_len * 3 + 20) * CLK_PERIOD;
    #(limit_ns);
    $display("timeout: halt never arrived within %0d ns", limit_ns);
    $display("run stopped: %0d instructions retired, %0d errors", retired, error_count);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: src.f
+incdir+bench
common/rv_pkg.sv
common/rv_exec_if.sv
common/rv_rf_read_if.sv
src/rv_fetch_decode.sv
src/rv_regfile.sv
src/rv_execute.sv
src/rv_core.sv
bench/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - common/rv_pkg.sv
  - common/rv_exec_if.sv
  - common/rv_rf_read_if.sv
  - src/rv_fetch_decode.sv
  - src/rv_regfile.sv
  - src/rv_execute.sv
  - src/rv_core.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_rv_core.sv
